/* flist.f */
+incdir+include
hw/mam_pkg.sv
hw/mam_cmd_stage.sv
hw/mam_bus_arbiter.sv
hw/mam_sram.sv
hw/mam_subsystem_top.sv
tests/mam_tb.sv

/* hw/mam_bus_arbiter.sv */
`timescale 1ns/1ps

module mam_bus_arbiter (
  input  logic               ahb3_in_clk_i,
  input  logic               reset_i,
  // CPU master
  input  mam_pkg::mem_req_t  cpu_req_i,
  input  logic               cpu_lock_i,
  output mam_pkg::mem_rsp_t  cpu_rsp_o,
  // MAM master from the command stage
  input  mam_pkg::mem_req_t  mam_req_i,
  output mam_pkg::mem_rsp_t  mam_rsp_o,
  // Shared memory
  output mam_pkg::mem_req_t  mem_req_o,
  input  mam_pkg::mem_rsp_t  mem_rsp_i
);

  mam_pkg::arb_state_e state_q;
  mam_pkg::arb_state_e state_d;

  // CPU keeps asking while a transfer is held or the lock is up
  logic cpu_wants;

  assign cpu_wants = cpu_req_i.sel || cpu_lock_i;

  always_ff @(posedge ahb3_in_clk_i) begin
    if (reset_i) begin
      state_q <= mam_pkg::ARB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Next owner
  always_comb begin
    state_d = state_q;
    case (state_q)
      mam_pkg::ARB_IDLE: begin
        // MAM wins a tie from idle
        if (mam_req_i.sel) begin
          state_d = mam_pkg::ARB_MAM;
        end else if (cpu_wants) begin
          state_d = mam_pkg::ARB_CPU;
        end
      end
      mam_pkg::ARB_MAM: begin
        // Held until the command stage drops select after ready
        if (!mam_req_i.sel) begin
          state_d = cpu_wants ? mam_pkg::ARB_CPU : mam_pkg::ARB_IDLE;
        end
      end
      mam_pkg::ARB_CPU: begin
        // Locked sequence is never split by MAM
        if (!cpu_wants) begin
          state_d = mam_req_i.sel ? mam_pkg::ARB_MAM : mam_pkg::ARB_IDLE;
        end
      end
      default: begin
        state_d = mam_pkg::ARB_IDLE;
      end
    endcase
  end

  // Request and response routing
  // Only the owner reaches the memory, the other side sees zeros
  always_comb begin
    mem_req_o = '0;
    cpu_rsp_o = '0;
    mam_rsp_o = '0;
    case (state_q)
      mam_pkg::ARB_MAM: begin
        mem_req_o = mam_req_i;
        mam_rsp_o = mem_rsp_i;
      end
      mam_pkg::ARB_CPU: begin
        mem_req_o = cpu_req_i;
        cpu_rsp_o = mem_rsp_i;
      end
      default: begin
        mem_req_o = '0;
      end
    endcase
  end

  // Both masters never complete in the same cycle
  a_single_ready: assert property (
    @(posedge ahb3_in_clk_i) disable iff (reset_i)
    !(cpu_rsp_o.ready && mam_rsp_o.ready)
  );

  // Idle means no memory access
  a_no_sel_in_idle: assert property (
    @(posedge ahb3_in_clk_i) disable iff (reset_i)
    (state_q == mam_pkg::ARB_IDLE) |-> !mem_req_o.sel
  );

endmodule

/* hw/mam_cmd_stage.sv */
`timescale 1ns/1ps

module mam_cmd_stage (
  input  logic                 ahb3_in_clk_i,
  input  logic                 reset_i,
  // Debug host command, one-cycle strobe
  input  logic                 dbg_req_i,
  input  logic                 dbg_we_i,
  input  mam_pkg::word_addr_t  dbg_addr_i,
  input  mam_pkg::data_t       dbg_wdata_i,
  // Debug host status and result
  output logic                 dbg_busy_o,
  output logic                 dbg_done_o,
  output logic                 dbg_err_o,
  output mam_pkg::data_t       dbg_rdata_o,
  // Held request towards the arbiter
  output mam_pkg::mem_req_t    mam_req_o,
  input  mam_pkg::mem_rsp_t    mam_rsp_i
);

  // Command in flight, doubles as the request select
  logic busy_q;
  logic done_q;

  // Latched command
  logic                we_q;
  mam_pkg::word_addr_t addr_q;
  mam_pkg::data_t      wdata_q;

  // Latched result, held after the done pulse
  logic           err_q;
  mam_pkg::data_t rdata_q;

  logic accept_cmd;
  logic finish_cmd;

  // Strobes while busy are dropped
  assign accept_cmd = dbg_req_i && !busy_q;
  // Memory answered the pending command
  assign finish_cmd = busy_q && mam_rsp_i.ready;

  always_ff @(posedge ahb3_in_clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= finish_cmd;
      if (accept_cmd) begin
        busy_q <= 1'b1;
      end else if (finish_cmd) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge ahb3_in_clk_i) begin
    if (accept_cmd) begin
      we_q    <= dbg_we_i;
      addr_q  <= dbg_addr_i;
      wdata_q <= dbg_wdata_i;
    end
    // Capture data and error in the ready cycle
    if (finish_cmd) begin
      err_q   <= mam_rsp_i.err;
      rdata_q <= mam_rsp_i.rdata;
    end
  end

  // Request stays stable until ready, select drops on the ready edge
  assign mam_req_o = '{sel: busy_q, write: we_q, addr: addr_q, wdata: wdata_q};

  assign dbg_busy_o  = busy_q;
  assign dbg_done_o  = done_q;
  assign dbg_err_o   = err_q;
  assign dbg_rdata_o = rdata_q;

  // Host must wait for done before the next strobe
  a_no_strobe_while_busy: assert property (
    @(posedge ahb3_in_clk_i) disable iff (reset_i)
    dbg_req_i |-> !busy_q
  );

  // Arbiter never routes a ready to MAM without a pending command
  a_ready_only_when_pending: assert property (
    @(posedge ahb3_in_clk_i) disable iff (reset_i)
    mam_rsp_i.ready |-> busy_q
  );

endmodule

/* hw/mam_pkg.sv */
package mam_pkg;

  `include "mam_defines.svh"

  // One memory data word
  typedef logic [`MAM_DATA_WIDTH-1:0] data_t;

  // Word address, covers more than the implemented depth
  typedef logic [`MAM_ADDR_WIDTH-1:0] word_addr_t;

  // Request held by a master until it sees ready
  typedef struct packed {
    logic       sel;
    logic       write;
    word_addr_t addr;
    data_t      wdata;
  } mem_req_t;

  // Response, all fields valid in the single ready cycle
  typedef struct packed {
    logic  ready;
    logic  err;
    data_t rdata;
  } mem_rsp_t;

  // Memory ownership
  typedef enum logic [1:0] {
    ARB_IDLE = 2'd0,
    ARB_MAM  = 2'd1,
    ARB_CPU  = 2'd2
  } arb_state_e;

endpackage

/* hw/mam_sram.sv */
`timescale 1ns/1ps

`include "mam_defines.svh"

module mam_sram (
  input  logic               ahb3_in_clk_i,
  input  logic               reset_i,
  input  mam_pkg::mem_req_t  mem_req_i,
  output mam_pkg::mem_rsp_t  mem_rsp_o
);

  // Index bits of the implemented array
  localparam int unsigned IDX_W = $clog2(`MAM_MEM_WORDS);

  // Word storage
  mam_pkg::data_t mem_q [`MAM_MEM_WORDS];

  // Registered response
  logic           ready_q;
  logic           err_q;
  mam_pkg::data_t rdata_q;

  logic             accept;
  logic             in_range;
  logic [IDX_W-1:0] idx;

  // Select is ignored in the ready cycle, the held request is already done
  assign accept   = mem_req_i.sel && !ready_q;
  assign in_range = mem_req_i.addr < mam_pkg::word_addr_t'(`MAM_MEM_WORDS);
  assign idx      = mem_req_i.addr[IDX_W-1:0];

  always_ff @(posedge ahb3_in_clk_i) begin
    if (reset_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
    end
  end

  // Out of range writes leave the array untouched
  always_ff @(posedge ahb3_in_clk_i) begin
    if (accept && mem_req_i.write && in_range) begin
      mem_q[idx] <= mem_req_i.wdata;
    end
  end

  always_ff @(posedge ahb3_in_clk_i) begin
    if (accept) begin
      err_q <= !in_range;
      // Zero data on writes and on errors
      if (!mem_req_i.write && in_range) begin
        rdata_q <= mem_q[idx];
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign mem_rsp_o = '{ready: ready_q, err: err_q, rdata: rdata_q};

  // Granted master holds select and address through its ready cycle
  a_req_held: assert property (
    @(posedge ahb3_in_clk_i) disable iff (reset_i)
    accept |=> mem_req_i.sel && $stable(mem_req_i.addr)
  );

endmodule

/* hw/mam_subsystem_top.sv */
`timescale 1ns/1ps

module mam_subsystem_top (
  input  logic                 ahb3_in_clk_i,
  input  logic                 reset_i,
  // CPU bus port
  input  mam_pkg::mem_req_t    cpu_req_i,
  input  logic                 cpu_lock_i,
  output mam_pkg::mem_rsp_t    cpu_rsp_o,
  // Debug host port
  input  logic                 dbg_req_i,
  input  logic                 dbg_we_i,
  input  mam_pkg::word_addr_t  dbg_addr_i,
  input  mam_pkg::data_t       dbg_wdata_i,
  output logic                 dbg_busy_o,
  output logic                 dbg_done_o,
  output logic                 dbg_err_o,
  output mam_pkg::data_t       dbg_rdata_o
);

  // Command stage to arbiter
  mam_pkg::mem_req_t mam_req;
  mam_pkg::mem_rsp_t mam_rsp;

  // Arbiter to memory
  mam_pkg::mem_req_t mem_req;
  mam_pkg::mem_rsp_t mem_rsp;

  // Debug strobes become held MAM requests
  mam_cmd_stage u_cmd_stage (
    .ahb3_in_clk_i (ahb3_in_clk_i),
    .reset_i       (reset_i),
    .dbg_req_i     (dbg_req_i),
    .dbg_we_i      (dbg_we_i),
    .dbg_addr_i    (dbg_addr_i),
    .dbg_wdata_i   (dbg_wdata_i),
    .dbg_busy_o    (dbg_busy_o),
    .dbg_done_o    (dbg_done_o),
    .dbg_err_o     (dbg_err_o),
    .dbg_rdata_o   (dbg_rdata_o),
    .mam_req_o     (mam_req),
    .mam_rsp_i     (mam_rsp)
  );

  // CPU and MAM share the memory
  mam_bus_arbiter u_arbiter (
    .ahb3_in_clk_i (ahb3_in_clk_i),
    .reset_i       (reset_i),
    .cpu_req_i     (cpu_req_i),
    .cpu_lock_i    (cpu_lock_i),
    .cpu_rsp_o     (cpu_rsp_o),
    .mam_req_i     (mam_req),
    .mam_rsp_o     (mam_rsp),
    .mem_req_o     (mem_req),
    .mem_rsp_i     (mem_rsp)
  );

  mam_sram u_sram (
    .ahb3_in_clk_i (ahb3_in_clk_i),
    .reset_i       (reset_i),
    .mem_req_i     (mem_req),
    .mem_rsp_o     (mem_rsp)
  );

endmodule

/* include/mam_defines.svh */
`ifndef MAM_DEFINES_SVH
`define MAM_DEFINES_SVH

// Width of one memory data word
`define MAM_DATA_WIDTH 32

// Word address width seen by both masters
`define MAM_ADDR_WIDTH 10

// Implemented depth in words
// Word addresses at or above this value end with an error response
`define MAM_MEM_WORDS 512

`endif

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide by the pass message in the output
verilator --binary --timing --assert --top-module mam_tb -f flist.f -o mam_sim \
  && ./obj_dir/mam_sim | tee /dev/stderr | grep -F "All checks passed" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* tests/mam_tb.sv */
`timescale 1ns/1ps

`include "mam_defines.svh"

module mam_tb;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int N_CPU        = 8;
  localparam int N_DBG        = 6;
  localparam int N_RAND       = 12;
  // Transfers over all tests, sizes the watchdog
  localparam int NUM_XFERS = 2 * N_CPU + 2 * N_DBG + 4 + 2 + 4 + 6 + 2 * N_RAND;
  localparam int IDX_W     = $clog2(`MAM_MEM_WORDS);
  // First out-of-range word, also the alias bit of an in-range word
  localparam mam_pkg::word_addr_t DEPTH = mam_pkg::word_addr_t'(`MAM_MEM_WORDS);

  typedef struct packed {
    logic           err;
    mam_pkg::data_t data;
  } expect_t;

  // DUT ports, connected by name
  logic                ahb3_in_clk_i = 1'b0;
  logic                reset_i;
  mam_pkg::mem_req_t   cpu_req_i;
  logic                cpu_lock_i;
  mam_pkg::mem_rsp_t   cpu_rsp_o;
  logic                dbg_req_i;
  logic                dbg_we_i;
  mam_pkg::word_addr_t dbg_addr_i;
  mam_pkg::data_t      dbg_wdata_i;
  logic                dbg_busy_o;
  logic                dbg_done_o;
  logic                dbg_err_o;
  mam_pkg::data_t      dbg_rdata_o;

  // Shadow memory and the in-range words written so far
  mam_pkg::data_t      shadow [`MAM_MEM_WORDS];
  mam_pkg::word_addr_t written_q [$];
  // Completion times, used for the ordering test
  time                 dbg_done_at;
  time                 cpu_ready_at;
  int                  checks = 0;
  int                  errors = 0;

  mam_subsystem_top uut (.*);

  always #(CLK_PERIOD / 2) ahb3_in_clk_i = ~ahb3_in_clk_i;

  // Last value written, zero with err at or above the depth
  function automatic expect_t ref_read(input mam_pkg::word_addr_t addr);
    if (addr >= DEPTH) begin
      return '{err: 1'b1, data: '0};
    end
    return '{err: 1'b0, data: shadow[addr[IDX_W-1:0]]};
  endfunction

  // Out-of-range writes leave the shadow alone
  function automatic void model_write(input mam_pkg::word_addr_t addr,
                                     input mam_pkg::data_t data);
    if (addr < DEPTH) begin
      shadow[addr[IDX_W-1:0]] = data;
      written_q.push_back(addr);
    end
  endfunction

  function automatic mam_pkg::word_addr_t rand_addr();
    return mam_pkg::word_addr_t'($urandom % `MAM_MEM_WORDS);
  endfunction

  function automatic mam_pkg::word_addr_t pick_written();
    return written_q[$urandom % written_q.size()];
  endfunction

  task automatic check_value(input string name, input mam_pkg::data_t got,
                             input mam_pkg::data_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("MISMATCH %s got 0x%08h expected 0x%08h at %0t ns", name, got, want, $time);
    end
  endtask

  // CPU holds select until ready, drops it on the edge after
  task automatic cpu_xfer(input logic we, input mam_pkg::word_addr_t addr,
                          input mam_pkg::data_t wdata, output mam_pkg::data_t rdata);
    @(posedge ahb3_in_clk_i);
    cpu_req_i <= '{sel: 1'b1, write: we, addr: addr, wdata: wdata};
    @(negedge ahb3_in_clk_i);
    while (!cpu_rsp_o.ready) begin
      @(negedge ahb3_in_clk_i);
    end
    rdata = cpu_rsp_o.rdata;
    @(posedge ahb3_in_clk_i);
    cpu_req_i.sel <= 1'b0;
  endtask

  // One-cycle strobe, command fields stay put until the next strobe
  task automatic dbg_xfer(input logic we, input mam_pkg::word_addr_t addr,
                          input mam_pkg::data_t wdata, output mam_pkg::data_t rdata);
    @(posedge ahb3_in_clk_i);
    dbg_req_i   <= 1'b1;
    dbg_we_i    <= we;
    dbg_addr_i  <= addr;
    dbg_wdata_i <= wdata;
    @(posedge ahb3_in_clk_i);
    dbg_req_i <= 1'b0;
    @(negedge ahb3_in_clk_i);
    while (!dbg_done_o) begin
      @(negedge ahb3_in_clk_i);
    end
    rdata = dbg_rdata_o;
  endtask

  // Writes to random words and reads of written words on one port
  task automatic random_traffic(input logic on_dbg);
    mam_pkg::data_t      rd;
    mam_pkg::word_addr_t addr;
    logic                we;
    for (int i = 0; i < N_RAND; i++) begin
      repeat ($urandom % 4) @(posedge ahb3_in_clk_i);
      we   = ($urandom % 2) == 0;
      addr = we ? rand_addr() : pick_written();
      if (on_dbg) begin
        dbg_xfer(we, addr, $urandom, rd);
      end else begin
        cpu_xfer(we, addr, $urandom, rd);
      end
    end
  endtask

  // Compare every response with the reference in its completion cycle
  always @(negedge ahb3_in_clk_i) begin : compare_responses
    expect_t want;
    if (!reset_i && dbg_done_o) begin
      dbg_done_at = $time;
      want = ref_read(dbg_addr_i);
      check_value("dbg_err_o", mam_pkg::data_t'(dbg_err_o), mam_pkg::data_t'(want.err));
      check_value("dbg_busy_o", mam_pkg::data_t'(dbg_busy_o), '0);
      if (dbg_we_i) begin
        model_write(dbg_addr_i, dbg_wdata_i);
      end else begin
        check_value("dbg_rdata_o", dbg_rdata_o, want.data);
      end
    end
    if (!reset_i && cpu_rsp_o.ready) begin
      cpu_ready_at = $time;
      want = ref_read(cpu_req_i.addr);
      if (!cpu_req_i.sel) begin
        errors++;
        $display("CPU ready pulsed with no CPU request pending at %0t ns", $time);
      end
      check_value("cpu_rsp_o.err", mam_pkg::data_t'(cpu_rsp_o.err), mam_pkg::data_t'(want.err));
      if (cpu_req_i.write) begin
        model_write(cpu_req_i.addr, cpu_req_i.wdata);
      end else begin
        check_value("cpu_rsp_o.rdata", cpu_rsp_o.rdata, want.data);
      end
    end
  end

  initial begin : watchdog
    #((NUM_XFERS * 50 + RESET_CYCLES) * CLK_PERIOD);
    $display("Timeout: the tests did not finish in time");
    $display("Summary: %0d checks, %0d errors", checks, errors + 1);
    $display("Checks failed");
    $finish;
  end

  initial begin : stimulus
    mam_pkg::word_addr_t cpu_addrs [N_CPU];
    mam_pkg::word_addr_t dbg_addrs [N_DBG];
    mam_pkg::word_addr_t addr;
    mam_pkg::data_t      v [3];
    mam_pkg::data_t      rd_cpu;
    mam_pkg::data_t      rd_dbg;
    void'($urandom(32'h5b79));
    reset_i     = 1'b1;
    cpu_req_i   = '0;
    cpu_lock_i  = 1'b0;
    dbg_req_i   = 1'b0;
    dbg_we_i    = 1'b0;
    dbg_addr_i  = '0;
    dbg_wdata_i = '0;
    repeat (RESET_CYCLES) @(posedge ahb3_in_clk_i);
    reset_i <= 1'b0;
    @(negedge ahb3_in_clk_i);
    check_value("dbg_busy_o", mam_pkg::data_t'(dbg_busy_o), '0);

    // CPU writes one word per 64-word slice, then reads them back
    for (int i = 0; i < N_CPU; i++) begin
      cpu_addrs[i] = mam_pkg::word_addr_t'(i * 64 + ($urandom % 64));
      cpu_xfer(1'b1, cpu_addrs[i], $urandom, rd_cpu);
    end
    for (int i = 0; i < N_CPU; i++) begin
      cpu_xfer(1'b0, cpu_addrs[i], '0, rd_cpu);
    end

    // Debug writes and reads, plus readback of CPU-written words
    for (int i = 0; i < N_DBG; i++) begin
      dbg_addrs[i] = rand_addr();
      dbg_xfer(1'b1, dbg_addrs[i], $urandom, rd_dbg);
    end
    for (int i = 0; i < N_DBG; i++) begin
      dbg_xfer(1'b0, dbg_addrs[i], '0, rd_dbg);
    end
    for (int i = 0; i < 4; i++) begin
      dbg_xfer(1'b0, cpu_addrs[i], '0, rd_dbg);
    end

    // Strobe is registered by the command stage, so a CPU select one
    // cycle later meets the MAM request at the idle arbiter
    repeat (2) @(posedge ahb3_in_clk_i);
    fork
      dbg_xfer(1'b0, cpu_addrs[4], '0, rd_dbg);
      begin
        @(posedge ahb3_in_clk_i);
        cpu_xfer(1'b0, cpu_addrs[5], '0, rd_cpu);
      end
    join
    if (dbg_done_at >= cpu_ready_at) begin
      errors++;
      $display("Debug done did not arrive before the CPU ready pulse");
    end

    // Locked CPU writes one word three times while a debug read waits
    addr = rand_addr();
    foreach (v[i]) begin
      v[i] = $urandom;
    end
    @(posedge ahb3_in_clk_i);
    cpu_lock_i <= 1'b1;
    fork
      begin
        foreach (v[i]) begin
          cpu_xfer(1'b1, addr, v[i], rd_cpu);
        end
        cpu_lock_i <= 1'b0;
      end
      begin
        repeat (3) @(posedge ahb3_in_clk_i);
        dbg_xfer(1'b0, addr, '0, rd_dbg);
      end
    join
    check_value("dbg_rdata_o", rd_dbg, v[2]);

    // Out-of-range accesses alias an in-range word
    addr = cpu_addrs[6];
    v[0] = shadow[addr[IDX_W-1:0]];
    cpu_xfer(1'b1, addr | DEPTH, $urandom, rd_cpu);
    dbg_xfer(1'b1, addr | DEPTH, $urandom, rd_dbg);
    cpu_xfer(1'b0, addr | DEPTH, '0, rd_cpu);
    check_value("cpu_rsp_o.rdata", rd_cpu, '0);
    dbg_xfer(1'b0, addr | DEPTH, '0, rd_dbg);
    check_value("dbg_rdata_o", rd_dbg, '0);
    cpu_xfer(1'b0, addr, '0, rd_cpu);
    check_value("cpu_rsp_o.rdata", rd_cpu, v[0]);
    dbg_xfer(1'b0, addr, '0, rd_dbg);
    check_value("dbg_rdata_o", rd_dbg, v[0]);

    // Both masters at once
    fork
      random_traffic(1'b0);
      random_traffic(1'b1);
    join

    repeat (2) @(posedge ahb3_in_clk_i);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
